/* files.f */
logic/gpio_io_pkg.sv
logic/axi_io_bridge.sv
logic/gpio_bank.sv
logic/button_debounce.sv
logic/gpio_io_top.sv
tests/gpio_io_checker.sv
tests/gpio_io_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the GPIO I/O testbench with Verilator.
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -j 0 \
   --top-module gpio_io_tb \
   -f files.f > build.log 2>&1 \
   || { echo "build failed, see build.log"; exit 1; }

./obj_dir/Vgpio_io_tb > sim.log 2>&1

cat sim.log

grep -q "Testbench passed" sim.log \
   && { echo "simulation PASS"; exit 0; } \
   || { echo "simulation FAIL"; exit 1; }

/* tests/gpio_io_tb.sv */
// testbench for the GPIO I/O subsystem driving its AXI port from a table of operations
module gpio_io_tb import gpio_io_pkg::*; ();

   typedef enum int {OP_WR, OP_RD, OP_PADS, OP_RPADS, OP_PRESS, OP_GLITCH} op_kind_e;

   // stall of -1 asks for a random bready or rready stall
   typedef struct {
      op_kind_e        kind;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
      logic [ID_W-1:0]   id;
      int                stall;
      logic [DATA_W-1:0] exp_data;
      axi_resp_e         exp_resp;
   } op_t;

   localparam int N_OPS = 31;
   localparam int PERIOD = 40;
   localparam int HS_LIMIT = 50;

   logic              clk;
   logic              i_rst_n;
   axi_aw_t           i_aw;
   logic              i_awvalid;
   logic              o_awready;
   axi_w_t            i_w;
   logic              i_wvalid;
   logic              o_wready;
   axi_b_t            o_b;
   logic              o_bvalid;
   logic              i_bready;
   axi_ar_t           i_ar;
   logic              i_arvalid;
   logic              o_arready;
   axi_r_t            o_r;
   logic              o_rvalid;
   logic              i_rready;
   logic [GPIO_W-1:0] i_gpio_in;
   logic [GPIO_W-1:0] o_gpio_out;
   logic [GPIO_W-1:0] o_gpio_oe;
   logic [BTN_W-1:0]  i_btn;
   logic              o_irq;

   op_t               ops [N_OPS];
   integer            seed;

   // reference model, index 0 is board GPIO and index 1 the button bank
   logic [DATA_W-1:0] m_in   [2];
   logic [DATA_W-1:0] m_out  [2];
   logic [DATA_W-1:0] m_oe   [2];
   logic [DATA_W-1:0] m_inte [2];
   logic [DATA_W-1:0] m_ints [2];

   gpio_io_top gpio_io_top_i (.*);

   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD / 2) clk = ~clk;
      end
   end

   // every operation fits well inside DEBOUNCE_CYCLES + 40 cycles
   initial begin
      #(N_OPS * (DEBOUNCE_CYCLES + 40) * PERIOD);
      $display("timeout, the run did not finish in time");
      $display("Testbench failed");
      $fatal(1);
   end

   // **************************************************
   // reporting and compare tasks
   // **************************************************
   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic check_b(input axi_b_t got, input axi_b_t exp);
      if (got !== exp) begin
         fail_now($sformatf("MISMATCH o_b got %h exp %h", got, exp));
      end
   endtask

   task automatic check_r(input axi_r_t got, input axi_r_t exp);
      if (got !== exp) begin
         fail_now($sformatf("MISMATCH o_r got %h exp %h", got, exp));
      end
   endtask

   task automatic check_pads(input string name, input logic [GPIO_W-1:0] got,
                             input logic [GPIO_W-1:0] exp);
      if (got !== exp) begin
         fail_now($sformatf("MISMATCH %s got %h exp %h", name, got, exp));
      end
   endtask

   task automatic check_irq(input logic got, input logic exp);
      if (got !== exp) begin
         fail_now($sformatf("MISMATCH o_irq got %h exp %h", got, exp));
      end
   endtask

   // **************************************************
   // reference model
   // **************************************************
   function automatic logic [DATA_W-1:0] bank_mask(input logic bank);
      return bank ? DATA_W'((1 << BTN_W) - 1) : '1;
   endfunction

   function automatic logic [DATA_W-1:0] byte_mask(input logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] m;
      for (int b = 0; b < STRB_W; b++) begin
         m[8*b +: 8] = {8{strb[b]}};
      end
      return m;
   endfunction

   // a rising edge on an enabled input latches its status bit
   task automatic model_pads(input logic bank, input logic [DATA_W-1:0] val);
      m_ints[bank] |= val & ~m_in[bank] & m_inte[bank];
      m_in[bank] = val;
   endtask

   task automatic model_write(input op_t op, output axi_resp_e resp);
      logic              bank;
      logic [2:0]        rg;
      logic [DATA_W-1:0] msk;
      bank = op.addr[BANK_SEL_BIT];
      rg   = op.addr[4:2];
      msk  = byte_mask(op.strb) & bank_mask(bank);
      resp = (rg > 3'd4) ? RESP_SLVERR : RESP_OKAY;
      case (rg)
         3'd1: m_out[bank]  = (m_out[bank] & ~msk) | (op.data & msk);
         3'd2: m_oe[bank]   = (m_oe[bank] & ~msk) | (op.data & msk);
         3'd3: m_inte[bank] = (m_inte[bank] & ~msk) | (op.data & msk);
         3'd4: m_ints[bank] = m_ints[bank] & ~(op.data & msk);
         default: ;
      endcase
   endtask

   task automatic model_read(input op_t op, output logic [DATA_W-1:0] d,
                             output axi_resp_e resp);
      logic bank;
      bank = op.addr[BANK_SEL_BIT];
      resp = RESP_OKAY;
      case (op.addr[4:2])
         3'd0: d = m_in[bank];
         3'd1: d = m_out[bank];
         3'd2: d = m_oe[bank];
         3'd3: d = m_inte[bank];
         3'd4: d = m_ints[bank];
         default: begin
            d    = '0;
            resp = RESP_SLVERR;
         end
      endcase
   endtask

   // **************************************************
   // bus tasks
   // **************************************************
   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   // hold the response back, offering a request of the same kind that must not be accepted
   task automatic stall_resp(input int n, input logic is_b);
      if (is_b) begin
         i_aw      = '{id: 4'hf, addr: 16'h0004};
         i_w       = '{data: '0, strb: '0};
         i_awvalid = 1'b1;
         i_wvalid  = 1'b1;
      end else begin
         i_ar      = '{id: 4'hf, addr: 16'h0004};
         i_arvalid = 1'b1;
      end
      repeat (n) begin
         @(negedge clk);
         #1;
         if ((is_b ? o_bvalid : o_rvalid) !== 1'b1) begin
            fail_now("response valid dropped while the master stalled");
         end
         if (o_arready !== 1'b0 || o_awready !== 1'b0 || o_wready !== 1'b0) begin
            fail_now("a new request was accepted while a response was pending");
         end
      end
   endtask

   task automatic wait_flag(input logic is_b, input int which);
      int n;
      n = 0;
      #1;
      while ((which == 0 ? (is_b ? o_awready : o_arready)
                         : (is_b ? o_bvalid : o_rvalid)) !== 1'b1) begin
         @(negedge clk);
         #1;
         n++;
         if (n > HS_LIMIT) begin
            fail_now("handshake never completed");
         end
      end
   endtask

   task automatic do_write(input op_t op, input int stall);
      i_aw      = '{id: op.id, addr: op.addr};
      i_w       = '{data: op.data, strb: op.strb};
      i_awvalid = 1'b1;
      i_wvalid  = 1'b1;
      wait_flag(1'b1, 0);
      // address and data are taken in the same cycle
      if (o_wready !== 1'b1) begin
         fail_now($sformatf("MISMATCH o_wready got %h exp %h", o_wready, 1'b1));
      end
      @(negedge clk);
      i_awvalid = 1'b0;
      i_wvalid  = 1'b0;
      wait_flag(1'b1, 1);
      check_b(o_b, '{id: op.id, resp: op.exp_resp});
      stall_resp(stall, 1'b1);
      i_bready = 1'b1;
      @(negedge clk);
      i_bready  = 1'b0;
      i_awvalid = 1'b0;
      i_wvalid  = 1'b0;
   endtask

   task automatic do_read(input op_t op, input int stall);
      i_ar      = '{id: op.id, addr: op.addr};
      i_arvalid = 1'b1;
      wait_flag(1'b0, 0);
      @(negedge clk);
      i_arvalid = 1'b0;
      wait_flag(1'b0, 1);
      check_r(o_r, '{id: op.id, data: op.exp_data, resp: op.exp_resp, last: 1'b1});
      stall_resp(stall, 1'b0);
      i_rready = 1'b1;
      @(negedge clk);
      i_rready  = 1'b0;
      i_arvalid = 1'b0;
   endtask

   function automatic op_t mk(input op_kind_e k, input logic [ADDR_W-1:0] a,
                              input logic [DATA_W-1:0] d, input logic [STRB_W-1:0] s,
                              input logic [ID_W-1:0] id, input int stall);
      op_t o;
      o = '{kind: k, addr: a, data: d, strb: s, id: id, stall: stall,
            exp_data: '0, exp_resp: RESP_OKAY};
      return o;
   endfunction

   // **************************************************
   // operation table
   // **************************************************
   initial begin
      ops[0]  = mk(OP_WR,     16'h0004, 32'ha5a5_5a5a, 4'hf, 4'h1, -1);
      ops[1]  = mk(OP_RD,     16'h0004, 32'h0,         4'hf, 4'h2, -1);
      ops[2]  = mk(OP_WR,     16'h0008, 32'hffff_0000, 4'hf, 4'h3, -1);
      ops[3]  = mk(OP_WR,     16'h0004, 32'h1234_5678, 4'h5, 4'h4, -1);
      ops[4]  = mk(OP_RD,     16'h0004, 32'h0,         4'hf, 4'h5, -1);
      ops[5]  = mk(OP_WR,     16'h0008, 32'h0000_00ff, 4'h1, 4'h6, 3);
      ops[6]  = mk(OP_RPADS,  16'h0000, 32'h0,         4'h0, 4'h0, 0);
      ops[7]  = mk(OP_RD,     16'h0000, 32'h0,         4'hf, 4'h7, -1);
      ops[8]  = mk(OP_RPADS,  16'h0000, 32'h0,         4'h0, 4'h0, 0);
      ops[9]  = mk(OP_RD,     16'h0000, 32'h0,         4'hf, 4'h8, -1);
      ops[10] = mk(OP_WR,     16'h0014, 32'hffff_ffff, 4'hf, 4'h9, -1);
      ops[11] = mk(OP_RD,     16'h001c, 32'h0,         4'hf, 4'ha, -1);
      ops[12] = mk(OP_RD,     16'h0004, 32'h0,         4'hf, 4'hb, -1);
      ops[13] = mk(OP_WR,     16'h0118, 32'hffff_ffff, 4'hf, 4'hc, -1);
      ops[14] = mk(OP_PADS,   16'h0000, 32'h0,         4'h0, 4'h0, 0);
      ops[15] = mk(OP_WR,     16'h000c, 32'h0000_0001, 4'hf, 4'hd, -1);
      ops[16] = mk(OP_PADS,   16'h0000, 32'h0000_0001, 4'h0, 4'h0, 0);
      ops[17] = mk(OP_RD,     16'h0010, 32'h0,         4'hf, 4'he, -1);
      ops[18] = mk(OP_WR,     16'h0010, 32'h0000_0001, 4'hf, 4'h1, -1);
      ops[19] = mk(OP_RD,     16'h0010, 32'h0,         4'hf, 4'h2, -1);
      // the button interrupt is armed first, so a glitch that slipped through would raise o_irq
      ops[20] = mk(OP_WR,     16'h010c, 32'h0000_0001, 4'hf, 4'h4, -1);
      ops[21] = mk(OP_GLITCH, 16'h0000, 32'h0000_0001, 4'h0, 4'h0, 0);
      ops[22] = mk(OP_RD,     16'h0100, 32'h0,         4'hf, 4'h3, -1);
      ops[23] = mk(OP_PRESS,  16'h0000, 32'h0000_0001, 4'h0, 4'h0, 0);
      ops[24] = mk(OP_RD,     16'h0100, 32'h0,         4'hf, 4'h5, -1);
      ops[25] = mk(OP_RD,     16'h0110, 32'h0,         4'hf, 4'h6, -1);
      ops[26] = mk(OP_WR,     16'h0110, 32'h0000_0001, 4'h1, 4'h7, -1);
      ops[27] = mk(OP_PRESS,  16'h0000, 32'h0000_0000, 4'h0, 4'h0, 0);
      ops[28] = mk(OP_RD,     16'h0110, 32'h0,         4'hf, 4'h8, -1);
      ops[29] = mk(OP_WR,     16'h0000, 32'hffff_ffff, 4'hf, 4'h9, -1);
      ops[30] = mk(OP_RD,     16'h0000, 32'h0,         4'hf, 4'ha, -1);
   end

   // **************************************************
   // main sequence
   // **************************************************
   initial begin
      int stall;
      seed      = 32'h2754_763a;
      i_rst_n   = 1'b0;
      i_aw      = '0;
      i_awvalid = 1'b0;
      i_w       = '0;
      i_wvalid  = 1'b0;
      i_bready  = 1'b0;
      i_ar      = '0;
      i_arvalid = 1'b0;
      i_rready  = 1'b0;
      i_gpio_in = '0;
      i_btn     = '0;
      for (int b = 0; b < 2; b++) begin
         m_in[b]   = '0;
         m_out[b]  = '0;
         m_oe[b]   = '0;
         m_inte[b] = '0;
         m_ints[b] = '0;
      end
      wait_cycles(2);
      i_rst_n = 1'b1;
      wait_cycles(2);
      check_pads("o_gpio_out", o_gpio_out, '0);
      check_pads("o_gpio_oe", o_gpio_oe, '0);
      check_irq(o_irq, 1'b0);

      for (int i = 0; i < N_OPS; i++) begin
         stall = (ops[i].stall < 0) ? int'($unsigned($random(seed)) % 4) : ops[i].stall;
         case (ops[i].kind)
            OP_WR: begin
               model_write(ops[i], ops[i].exp_resp);
               do_write(ops[i], stall);
            end
            OP_RD: begin
               model_read(ops[i], ops[i].exp_data, ops[i].exp_resp);
               do_read(ops[i], stall);
            end
            OP_PADS, OP_RPADS: begin
               if (ops[i].kind == OP_RPADS) begin
                  ops[i].data = $random(seed);
               end
               i_gpio_in = ops[i].data;
               model_pads(1'b0, ops[i].data);
               wait_cycles(5);
            end
            OP_PRESS: begin
               i_btn = ops[i].data[BTN_W-1:0];
               model_pads(1'b1, ops[i].data);
               wait_cycles(2 * DEBOUNCE_CYCLES + 4);
            end
            default: begin
               // a glitch shorter than the filter window leaves the model alone
               i_btn = ops[i].data[BTN_W-1:0];
               wait_cycles(DEBOUNCE_CYCLES / 2);
               i_btn = m_in[1][BTN_W-1:0];
               wait_cycles(DEBOUNCE_CYCLES + 4);
            end
         endcase
         check_pads("o_gpio_out", o_gpio_out, m_out[0]);
         check_pads("o_gpio_oe", o_gpio_oe, m_oe[0]);
         check_irq(o_irq, (|m_ints[0]) || (|m_ints[1]));
      end

      $display("Testbench passed");
      $finish;
   end

endmodule

/* tests/gpio_io_checker.sv */
// bound assertions on AXI response handshakes and reset state of the GPIO I/O top level
module gpio_io_checker import gpio_io_pkg::*; (
   input logic   clk,
   input logic   i_rst_n,
   input axi_b_t o_b,
   input logic   o_bvalid,
   input logic   i_bready,
   input axi_r_t o_r,
   input logic   o_rvalid,
   input logic   i_rready
);

   // **************************************************
   // reset state
   // **************************************************
   a_no_valid_in_reset: assert property (
      @(posedge clk) !i_rst_n |-> (!o_bvalid && !o_rvalid))
      else $error("response valid high during reset");

   // **************************************************
   // response stability under back-pressure
   // **************************************************

   // a stalled write response keeps valid and payload
   a_b_stable: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      (o_bvalid && !i_bready) |=> (o_bvalid && $stable(o_b)))
      else $error("write response changed while stalled");

   a_r_stable: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      (o_rvalid && !i_rready) |=> (o_rvalid && $stable(o_r)))
      else $error("read response changed while stalled");

   // single-beat reads, so every read beat is the last one
   a_r_last: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      o_rvalid |-> o_r.last)
      else $error("read response without last");

endmodule

bind gpio_io_top gpio_io_checker gpio_io_checker_i (
   .clk      (clk),
   .i_rst_n  (i_rst_n),
   .o_b      (o_b),
   .o_bvalid (o_bvalid),
   .i_bready (i_bready),
   .o_r      (o_r),
   .o_rvalid (o_rvalid),
   .i_rready (i_rready)
);

/* logic/gpio_io_top.sv */
// peripheral I/O top level with an AXI slave port, board GPIO and debounced pushbuttons
module gpio_io_top import gpio_io_pkg::*; (
   input  logic              clk,
   input  logic              i_rst_n,
   // AXI slave port
   input  axi_aw_t           i_aw,
   input  logic              i_awvalid,
   output logic              o_awready,
   input  axi_w_t            i_w,
   input  logic              i_wvalid,
   output logic              o_wready,
   output axi_b_t            o_b,
   output logic              o_bvalid,
   input  logic              i_bready,
   input  axi_ar_t           i_ar,
   input  logic              i_arvalid,
   output logic              o_arready,
   output axi_r_t            o_r,
   output logic              o_rvalid,
   input  logic              i_rready,
   // pads, no tristate cells here so in, out and enable are separate
   input  logic [GPIO_W-1:0] i_gpio_in,
   output logic [GPIO_W-1:0] o_gpio_out,
   output logic [GPIO_W-1:0] o_gpio_oe,
   input  logic [BTN_W-1:0]  i_btn,
   output logic              o_irq
);

   wb_req_t          wb_req;
   logic             gpio_sel;
   logic             btn_sel;
   wb_rsp_t          gpio_rsp;
   wb_rsp_t          btn_rsp;
   logic [BTN_W-1:0] btn_db;
   logic             gpio_irq;
   logic             btn_irq;

   // **************************************************
   // bus bridge
   // **************************************************
   axi_io_bridge axi_io_bridge_i (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_aw       (i_aw),
      .i_awvalid  (i_awvalid),
      .o_awready  (o_awready),
      .i_w        (i_w),
      .i_wvalid   (i_wvalid),
      .o_wready   (o_wready),
      .o_b        (o_b),
      .o_bvalid   (o_bvalid),
      .i_bready   (i_bready),
      .i_ar       (i_ar),
      .i_arvalid  (i_arvalid),
      .o_arready  (o_arready),
      .o_r        (o_r),
      .o_rvalid   (o_rvalid),
      .i_rready   (i_rready),
      .o_wb_req   (wb_req),
      .o_gpio_sel (gpio_sel),
      .o_btn_sel  (btn_sel),
      .i_gpio_rsp (gpio_rsp),
      .i_btn_rsp  (btn_rsp)
   );

   // **************************************************
   // GPIO banks
   // **************************************************
   gpio_bank #(.WIDTH(GPIO_W)) board_gpio (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_wb_req  (wb_req),
      .i_sel     (gpio_sel),
      .o_wb_rsp  (gpio_rsp),
      .i_pad_in  (i_gpio_in),
      .o_pad_out (o_gpio_out),
      .o_pad_oe  (o_gpio_oe),
      .o_irq     (gpio_irq)
   );

   // buttons are cleaned up before the bank sees them
   button_debounce button_debounce_i (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_btn    (i_btn),
      .o_btn_db (btn_db)
   );

   // button pads are input only, their out and enable registers drive nothing
   gpio_bank #(.WIDTH(BTN_W)) button_gpio (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_wb_req  (wb_req),
      .i_sel     (btn_sel),
      .o_wb_rsp  (btn_rsp),
      .i_pad_in  (btn_db),
      .o_pad_out (),
      .o_pad_oe  (),
      .o_irq     (btn_irq)
   );

   // one shared level interrupt for both banks
   assign o_irq = gpio_irq | btn_irq;

endmodule

/* logic/button_debounce.sv */
// pushbutton filter that passes a level only after it has held for DEBOUNCE_CYCLES cycles
module button_debounce import gpio_io_pkg::*; (
   input  logic             clk,
   input  logic             i_rst_n,
   input  logic [BTN_W-1:0] i_btn,
   output logic [BTN_W-1:0] o_btn_db
);

   localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

   logic [BTN_W-1:0] btn_meta;
   logic [BTN_W-1:0] btn_sync;
   logic [BTN_W-1:0] btn_db;
   logic [CNT_W-1:0] cnt [BTN_W];

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         btn_meta <= '0;
         btn_sync <= '0;
         btn_db   <= '0;
         for (int i = 0; i < BTN_W; i++) begin
            cnt[i] <= '0;
         end
      end else begin
         btn_meta <= i_btn;
         btn_sync <= btn_meta;
         for (int i = 0; i < BTN_W; i++) begin
            if (btn_sync[i] == btn_db[i]) begin
               // level agrees with the output, so any partial count was a bounce
               cnt[i] <= '0;
            end else if (cnt[i] == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
               // the last of DEBOUNCE_CYCLES differing cycles in a row
               btn_db[i] <= btn_sync[i];
               cnt[i]    <= '0;
            end else begin
               cnt[i] <= cnt[i] + 1'b1;
            end
         end
      end
   end

   assign o_btn_db = btn_db;

endmodule

/* logic/gpio_bank.sv */
// GPIO register bank with input synchronizer, output and enable registers and edge interrupts
module gpio_bank import gpio_io_pkg::*; #(
   parameter int WIDTH = GPIO_W
) (
   input  logic             clk,
   input  logic             i_rst_n,
   input  wb_req_t          i_wb_req,
   input  logic             i_sel,
   output wb_rsp_t          o_wb_rsp,
   input  logic [WIDTH-1:0] i_pad_in,
   output logic [WIDTH-1:0] o_pad_out,
   output logic [WIDTH-1:0] o_pad_oe,
   output logic             o_irq
);

   // two flop synchronizer plus one more stage for edge detection
   logic [WIDTH-1:0]  pad_meta;
   logic [WIDTH-1:0]  pad_sync;
   logic [WIDTH-1:0]  pad_last;
   logic [WIDTH-1:0]  pad_rise;

   logic [WIDTH-1:0]  out_q;
   logic [WIDTH-1:0]  oe_q;
   logic [WIDTH-1:0]  inte_q;
   logic [WIDTH-1:0]  ints_q;
   logic [WIDTH-1:0]  ints_clr;

   gpio_reg_e         reg_sel;
   logic              mapped;
   logic              access;
   logic              wr_en;
   logic [WIDTH-1:0]  wmask;
   logic [WIDTH-1:0]  wdata;
   logic [WIDTH-1:0]  rd_val;
   logic [DATA_W-1:0] rd_ext;

   logic              rsp_ack;
   logic              rsp_err;
   logic [DATA_W-1:0] rsp_dat;

   // **************************************************
   // register decode
   // **************************************************
   assign reg_sel = gpio_reg_e'(i_wb_req.adr);

   always_comb begin
      mapped = 1'b1;
      rd_val = '0;
      case (reg_sel)
         REG_IN:   rd_val = pad_sync;
         REG_OUT:  rd_val = out_q;
         REG_OE:   rd_val = oe_q;
         REG_INTE: rd_val = inte_q;
         REG_INTS: rd_val = ints_q;
         default:  mapped = 1'b0;
      endcase
      // narrow banks read back with zeros above WIDTH
      rd_ext              = '0;
      rd_ext[WIDTH-1:0]   = rd_val;
   end

   // each register bit follows the strobe of the byte it sits in
   always_comb begin
      for (int i = 0; i < WIDTH; i++) begin
         wmask[i] = i_wb_req.sel[i / 8];
      end
   end

   assign wdata = i_wb_req.dat[WIDTH-1:0];

   // a cycle is served once, the answer itself ends it
   assign access = i_sel && i_wb_req.stb && !rsp_ack && !rsp_err;
   assign wr_en  = access && mapped && i_wb_req.we;

   // write 1 to clear, only bits enabled by the byte strobes
   assign ints_clr = (wr_en && reg_sel == REG_INTS) ? (wdata & wmask) : '0;
   assign pad_rise = pad_sync & ~pad_last;

   // **************************************************
   // control registers
   // **************************************************
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pad_meta <= '0;
         pad_sync <= '0;
         pad_last <= '0;
         out_q    <= '0;
         oe_q     <= '0;
         inte_q   <= '0;
         ints_q   <= '0;
         rsp_ack  <= 1'b0;
         rsp_err  <= 1'b0;
      end else begin
         pad_meta <= i_pad_in;
         pad_sync <= pad_meta;
         pad_last <= pad_sync;
         rsp_ack  <= access && mapped;
         rsp_err  <= access && !mapped;
         // REG_IN writes are acknowledged and dropped
         if (wr_en && reg_sel == REG_OUT) begin
            out_q <= (out_q & ~wmask) | (wdata & wmask);
         end
         if (wr_en && reg_sel == REG_OE) begin
            oe_q <= (oe_q & ~wmask) | (wdata & wmask);
         end
         if (wr_en && reg_sel == REG_INTE) begin
            inte_q <= (inte_q & ~wmask) | (wdata & wmask);
         end
         // a new edge in the same cycle as a clear keeps its bit set
         ints_q <= (ints_q & ~ints_clr) | (pad_rise & inte_q);
      end
   end

   // read data, zero on an unmapped offset
   always_ff @(posedge clk) begin
      if (access) begin
         rsp_dat <= mapped ? rd_ext : '0;
      end
   end

   assign o_wb_rsp  = '{dat: rsp_dat, ack: rsp_ack, err: rsp_err};
   assign o_pad_out = out_q;
   assign o_pad_oe  = oe_q;
   assign o_irq     = |ints_q;

endmodule

/* logic/axi_io_bridge.sv */
// single-beat AXI slave that turns each request into one Wishbone cycle on a GPIO bank
module axi_io_bridge import gpio_io_pkg::*; (
   input  logic    clk,
   input  logic    i_rst_n,
   // write address and data
   input  axi_aw_t i_aw,
   input  logic    i_awvalid,
   output logic    o_awready,
   input  axi_w_t  i_w,
   input  logic    i_wvalid,
   output logic    o_wready,
   // write response
   output axi_b_t  o_b,
   output logic    o_bvalid,
   input  logic    i_bready,
   // read address and data
   input  axi_ar_t i_ar,
   input  logic    i_arvalid,
   output logic    o_arready,
   output axi_r_t  o_r,
   output logic    o_rvalid,
   input  logic    i_rready,
   // Wishbone side
   output wb_req_t o_wb_req,
   output logic    o_gpio_sel,
   output logic    o_btn_sel,
   input  wb_rsp_t i_gpio_rsp,
   input  wb_rsp_t i_btn_rsp
);

   bridge_state_e     state;
   bridge_state_e     state_nxt;
   logic              run_q;

   // request captured at the handshake
   logic [ID_W-1:0]   id_q;
   logic              bank_q;
   logic [2:0]        adr_q;
   logic [DATA_W-1:0] dat_q;
   logic [STRB_W-1:0] sel_q;
   logic              we_q;

   // response captured when the bank answers
   axi_resp_e         resp_q;
   logic [DATA_W-1:0] rdata_q;

   logic              idle;
   logic              wr_hs;
   logic              rd_hs;
   logic              in_wb;
   wb_rsp_t           bank_rsp;
   logic              bank_done;

   // **************************************************
   // AXI handshakes
   // **************************************************

   // run_q holds every ready low for the first cycle after reset is released
   assign idle = run_q && (state == ST_IDLE);

   // address and data are taken together, so both valids must be up
   assign o_awready = idle && i_awvalid && i_wvalid;
   assign o_wready  = idle && i_awvalid && i_wvalid;
   assign wr_hs     = o_awready;

   // a read only goes when no complete write is on offer, writes win
   assign o_arready = idle && i_arvalid && !(i_awvalid && i_wvalid);
   assign rd_hs     = o_arready;

   // **************************************************
   // FSM
   // **************************************************
   assign in_wb = (state == ST_WB_WR) || (state == ST_WB_RD);

   // only the bank picked by the stored address can finish the cycle
   assign bank_rsp  = bank_q ? i_btn_rsp : i_gpio_rsp;
   assign bank_done = in_wb && (bank_rsp.ack || bank_rsp.err);

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (wr_hs) begin
               state_nxt = ST_WB_WR;
            end else if (rd_hs) begin
               state_nxt = ST_WB_RD;
            end
         end
         ST_WB_WR: begin
            if (bank_done) begin
               state_nxt = ST_RESP_B;
            end
         end
         ST_WB_RD: begin
            if (bank_done) begin
               state_nxt = ST_RESP_R;
            end
         end
         // the response stays up until the master takes it
         ST_RESP_B: begin
            if (i_bready) begin
               state_nxt = ST_IDLE;
            end
         end
         ST_RESP_R: begin
            if (i_rready) begin
               state_nxt = ST_IDLE;
            end
         end
         default: state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= ST_IDLE;
         run_q <= 1'b0;
      end else begin
         state <= state_nxt;
         run_q <= 1'b1;
      end
   end

   // **************************************************
   // request and response capture
   // **************************************************
   always_ff @(posedge clk) begin
      if (wr_hs) begin
         id_q   <= i_aw.id;
         bank_q <= i_aw.addr[BANK_SEL_BIT];
         adr_q  <= i_aw.addr[4:2];
         dat_q  <= i_w.data;
         sel_q  <= i_w.strb;
         we_q   <= 1'b1;
      end else if (rd_hs) begin
         id_q   <= i_ar.id;
         bank_q <= i_ar.addr[BANK_SEL_BIT];
         adr_q  <= i_ar.addr[4:2];
         dat_q  <= '0;
         sel_q  <= '1;
         we_q   <= 1'b0;
      end
      // an error answer never returns data to the master
      if (bank_done) begin
         resp_q  <= bank_rsp.err ? RESP_SLVERR : RESP_OKAY;
         rdata_q <= bank_rsp.err ? '0 : bank_rsp.dat;
      end
   end

   // one request drives both banks, the per-bank strobe decides who answers
   assign o_wb_req   = '{adr: adr_q, dat: dat_q, sel: sel_q, we: we_q, stb: in_wb};
   assign o_gpio_sel = in_wb && !bank_q;
   assign o_btn_sel  = in_wb && bank_q;

   // responses carry the ID stored at the handshake, last is always set
   assign o_bvalid = (state == ST_RESP_B);
   assign o_b      = '{id: id_q, resp: resp_q};
   assign o_rvalid = (state == ST_RESP_R);
   assign o_r      = '{id: id_q, data: rdata_q, resp: resp_q, last: 1'b1};

endmodule

/* logic/gpio_io_pkg.sv */
// shared widths, address map, enums and bus structs for the GPIO I/O subsystem
package gpio_io_pkg;

   // **************************************************
   // widths
   // **************************************************
   localparam int ID_W   = 4;
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;
   localparam int STRB_W = 4;
   localparam int GPIO_W = 32;
   localparam int BTN_W  = 5;

   // a synchronized button level must hold this many cycles in a row before it is accepted
   localparam int DEBOUNCE_CYCLES = 16;

   // address bit 8 picks the bank: 0 is board GPIO at 0x000, 1 is buttons at 0x100
   localparam int BANK_SEL_BIT = 8;

   // **************************************************
   // encodings
   // **************************************************

   // register offset taken from address bits 4 to 2, offsets 5 to 7 are unmapped
   typedef enum logic [2:0] {
      REG_IN   = 3'd0,  // byte offset 0x00, pad levels, read only
      REG_OUT  = 3'd1,  // byte offset 0x04, pad output values
      REG_OE   = 3'd2,  // byte offset 0x08, pad output enables
      REG_INTE = 3'd3,  // byte offset 0x0C, rising edge interrupt enables
      REG_INTS = 3'd4   // byte offset 0x10, interrupt status, write 1 to clear
   } gpio_reg_e;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'd0,
      RESP_SLVERR = 2'd2
   } axi_resp_e;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_WB_WR,
      ST_WB_RD,
      ST_RESP_B,
      ST_RESP_R
   } bridge_state_e;

   // **************************************************
   // AXI channel payloads, valid and ready travel beside them
   // **************************************************
   typedef struct packed {
      logic [ID_W-1:0]   id;
      logic [ADDR_W-1:0] addr;
   } axi_aw_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
   } axi_w_t;

   typedef struct packed {
      logic [ID_W-1:0] id;
      axi_resp_e       resp;
   } axi_b_t;

   typedef struct packed {
      logic [ID_W-1:0]   id;
      logic [ADDR_W-1:0] addr;
   } axi_ar_t;

   typedef struct packed {
      logic [ID_W-1:0]   id;
      logic [DATA_W-1:0] data;
      axi_resp_e         resp;
      logic              last;
   } axi_r_t;

   // Wishbone request from the bridge, stb also serves as cyc
   typedef struct packed {
      logic [2:0]        adr;  // register offset only, a gpio_reg_e value or unmapped
      logic [DATA_W-1:0] dat;
      logic [STRB_W-1:0] sel;
      logic              we;
      logic              stb;
   } wb_req_t;

   // answer from one bank, exactly one of ack or err per cycle
   typedef struct packed {
      logic [DATA_W-1:0] dat;
      logic              ack;
      logic              err;
   } wb_rsp_t;

endpackage
